/* rtl/console_pkg.sv */
/* board constants for the front-panel console
   imported by the debouncer, run control and display blocks */
package console_pkg;

   ////////////////////////////////////////
   // button filtering

   // equal samples needed before a button output flips
   localparam int DEBOUNCE_CYCLES   = 16;
   localparam int DEBOUNCE_CNT_BITS = $clog2(DEBOUNCE_CYCLES);

   // depth of every input synchronizer
   localparam int SYNC_STAGES = 2;

   ////////////////////////////////////////
   // processor reset

   // cycles proc_rst_n stays low after master reset ends
   localparam int RESET_HOLD_CYCLES = 8;
   localparam int HOLD_CNT_BITS     = $clog2(RESET_HOLD_CYCLES);

   ////////////////////////////////////////
   // seven-segment display

   localparam int NUM_DIGITS = 8;   // digits on the board
   localparam int WORD_BITS  = 32;  // debug word, one nibble per digit
   localparam int SEG_BITS   = 7;   // segments a..g, no point

endpackage

/* rtl/panel_types_pkg.sv */
/* data types passed between the console blocks
   raw switch bundle, debounced panel state and display words */
package panel_types_pkg;

   // debug word shown on the digits
   typedef logic [console_pkg::WORD_BITS-1:0] debug_word_t;

   // one displayed nibble
   typedef logic [3:0] hex_digit_t;

   // segment bits g down to a, active high
   typedef logic [console_pkg::SEG_BITS-1:0] seg_pattern_t;

   // digit 0 is leftmost, shows the top nibble
   typedef seg_pattern_t [0:console_pkg::NUM_DIGITS-1] seg_bank_t;

   // raw panel inputs, buttons active high
   typedef struct packed {
      logic reset_btn;    // master reset button
      logic release_btn;  // release from break
      logic step_btn;     // single step button
      logic io_sel;       // io port select, passed to processor
      logic run_mode;     // 1 = free-running clock
      logic show_io;      // 1 = display io_word
      logic show_addr;    // 1 = pc_word, 0 = instr_word
   } panel_switches_t;

   // filtered and synchronized panel inputs
   typedef struct packed {
      logic reset_lvl;
      logic release_lvl;
      logic release_rise;  // one cycle
      logic step_rise;     // one cycle
      logic io_sel;
      logic run_mode;
      logic show_io;
      logic show_addr;
   } panel_state_t;

endpackage

/* rtl/button_debouncer.sv */
/* debouncer for one push button
   synchronizes the raw input, then flips level after a stable run */
`timescale 1ns/1ps

module button_debouncer (
   input  logic clk,
   input  logic rst_n,
   input  logic btn,
   output logic level,
   output logic rise
);
   import console_pkg::*;

   logic [SYNC_STAGES-1:0]       sync_q;  // sync chain, msb is oldest
   logic                         btn_s;   // synchronized button
   logic [DEBOUNCE_CNT_BITS-1:0] run_cnt; // samples differing from level
   logic                         run_full;

   assign btn_s    = sync_q[SYNC_STAGES-1];
   assign run_full = (run_cnt == DEBOUNCE_CNT_BITS'(DEBOUNCE_CYCLES - 1));

   ////////////////////////////////////////
   // synchronizer

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], btn};
      end
   end

   ////////////////////////////////////////
   // run-length filter

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run_cnt <= '0;
         level   <= 1'b0;
         rise    <= 1'b0;
      end else begin
         rise <= 1'b0;
         if (btn_s == level) begin
            run_cnt <= '0;            // glitch ended, start over
         end else if (run_full) begin
            run_cnt <= '0;
            level   <= btn_s;         // held long enough
            rise    <= btn_s;         // only on 0 -> 1
         end else begin
            run_cnt <= run_cnt + 1'b1;
         end
      end
   end

   // a rise needs the synced button high for a full run
   a_rise_level: assert property (@(posedge clk) disable iff (!rst_n)
      rise |-> level && $past(btn_s, DEBOUNCE_CYCLES));

endmodule

/* rtl/panel_inputs.sv */
/* front-panel input stage
   debounces reset, release and step, synchronizes the level switches
   and packs everything into one panel_state_t */
`timescale 1ns/1ps

module panel_inputs (
   input  logic                             clk,
   input  logic                             rst_n,
   input  panel_types_pkg::panel_switches_t sw,
   output panel_types_pkg::panel_state_t    state
);
   import console_pkg::*;

   logic                        reset_lvl;
   logic                        release_lvl;
   logic                        release_rise;
   logic                        step_rise;
   logic [3:0]                  lvl_in;   // io_sel, run_mode, show_io, show_addr
   logic [SYNC_STAGES-1:0][3:0] lvl_sync;
   logic [3:0]                  lvl_out;

   // reset only needs the level, step only the edge
   button_debouncer reset_db_i (
      .clk   (clk),
      .rst_n (rst_n),
      .btn   (sw.reset_btn),
      .level (reset_lvl),
      .rise  ()
   );

   button_debouncer release_db_i (
      .clk   (clk),
      .rst_n (rst_n),
      .btn   (sw.release_btn),
      .level (release_lvl),
      .rise  (release_rise)
   );

   button_debouncer step_db_i (
      .clk   (clk),
      .rst_n (rst_n),
      .btn   (sw.step_btn),
      .level (),
      .rise  (step_rise)
   );

   ////////////////////////////////////////
   // level switches, sync only

   assign lvl_in  = {sw.io_sel, sw.run_mode, sw.show_io, sw.show_addr};
   assign lvl_out = lvl_sync[SYNC_STAGES-1];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lvl_sync <= '0;
      end else begin
         lvl_sync[0] <= lvl_in;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            lvl_sync[i] <= lvl_sync[i-1];
         end
      end
   end

   always_comb begin
      state.reset_lvl    = reset_lvl;
      state.release_lvl  = release_lvl;
      state.release_rise = release_rise;
      state.step_rise    = step_rise;
      {state.io_sel, state.run_mode, state.show_io, state.show_addr} = lvl_out;
   end

endmodule

/* rtl/run_control.sv */
/* processor run control
   stretches the master reset, makes the processor clock enable
   and picks the release signal for run or step mode */
`timescale 1ns/1ps

module run_control (
   input  logic                          clk,
   input  logic                          rst_n,
   input  panel_types_pkg::panel_state_t state,
   output logic                          proc_rst_n,
   output logic                          proc_clk_en,
   output logic                          proc_release,
   output logic                          io_sel
);
   import console_pkg::*;

   logic [HOLD_CNT_BITS-1:0] hold_cnt;   // cycles since master reset ended
   logic                     hold_done;
   logic                     run_next;   // proc_rst_n for the next cycle

   assign hold_done = (hold_cnt == HOLD_CNT_BITS'(RESET_HOLD_CYCLES - 1));
   // reset button wins, otherwise stay up or come up at end of hold
   assign run_next  = ~state.reset_lvl & (proc_rst_n | hold_done);

   ////////////////////////////////////////
   // reset hold

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hold_cnt   <= '0;
         proc_rst_n <= 1'b0;
      end else begin
         proc_rst_n <= run_next;
         if (state.reset_lvl) begin
            hold_cnt <= '0;                    // restart the hold
         end else if (!proc_rst_n && !hold_done) begin
            hold_cnt <= hold_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // clock enable and release

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         proc_clk_en  <= 1'b0;
         proc_release <= 1'b0;
         io_sel       <= 1'b0;
      end else begin
         // free run or one tick per step press
         proc_clk_en  <= run_next & (state.run_mode | state.step_rise);
         proc_release <= run_next & (state.run_mode ? state.release_lvl
                                                    : state.release_rise);
         io_sel       <= state.io_sel;
      end
   end

   // no tick in reset, nor before the hold after a reset press has run
   a_no_en_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
      proc_clk_en |-> proc_rst_n && !$past(state.reset_lvl, RESET_HOLD_CYCLES));

   // step mode, debounced presses never give back-to-back ticks
   a_step_single: assert property (@(posedge clk) disable iff (!rst_n)
      (proc_clk_en && !$past(state.run_mode) && !$past(state.run_mode, 2))
      |-> !$past(proc_clk_en));

endmodule

/* rtl/display_capture.sv */
/* display word producer
   picks io, pc or instruction word from the panel switches and
   offers it to the display over a four-phase req/ack handshake */
`timescale 1ns/1ps

module display_capture (
   input  logic                          clk,
   input  logic                          rst_n,
   input  panel_types_pkg::panel_state_t state,
   input  panel_types_pkg::debug_word_t  io_word,
   input  panel_types_pkg::debug_word_t  pc_word,
   input  panel_types_pkg::debug_word_t  instr_word,
   input  logic                          disp_ack,
   output logic                          disp_req,
   output panel_types_pkg::debug_word_t  disp_word
);
   import panel_types_pkg::*;

   debug_word_t sel_word;   // word the switches ask for
   logic        idle;       // both handshake lines low

   assign idle = ~disp_req & ~disp_ack;

   always_comb begin
      if (state.show_io) begin
         sel_word = io_word;
      end else if (state.show_addr) begin
         sel_word = pc_word;     // current address
      end else begin
         sel_word = instr_word;  // current instruction
      end
   end

   ////////////////////////////////////////
   // producer side of req/ack

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         disp_req <= 1'b0;
      end else if (idle) begin
         disp_req <= 1'b1;         // phase 1, word goes out with req
      end else if (disp_req && disp_ack) begin
         disp_req <= 1'b0;         // phase 3
      end
   end

   // sampled once per transfer, held while req is up
   always_ff @(posedge clk) begin
      if (idle) begin
         disp_word <= sel_word;
      end
   end

   // held through req and through the consumer's ack
   a_word_stable: assert property (@(posedge clk) disable iff (!rst_n)
      ((disp_req && $past(disp_req)) || disp_ack) |-> disp_word == $past(disp_word));

endmodule

/* rtl/seg_display.sv */
/* display word consumer
   latches words from the req/ack handshake and decodes each nibble
   into a registered hex pattern, top nibble on the leftmost digit */
`timescale 1ns/1ps

module seg_display (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         disp_req,
   input  panel_types_pkg::debug_word_t disp_word,
   output logic                         disp_ack,
   output panel_types_pkg::seg_bank_t   seg
);
   import console_pkg::*;
   import panel_types_pkg::*;

   debug_word_t shown_word;   // last word latched
   seg_bank_t   seg_next;

   // standard hex font, bits g..a
   function automatic seg_pattern_t hex_to_seg(input hex_digit_t nib);
      case (nib)
         4'h0: hex_to_seg = 7'b0111111;
         4'h1: hex_to_seg = 7'b0000110;
         4'h2: hex_to_seg = 7'b1011011;
         4'h3: hex_to_seg = 7'b1001111;
         4'h4: hex_to_seg = 7'b1100110;
         4'h5: hex_to_seg = 7'b1101101;
         4'h6: hex_to_seg = 7'b1111101;
         4'h7: hex_to_seg = 7'b0000111;
         4'h8: hex_to_seg = 7'b1111111;
         4'h9: hex_to_seg = 7'b1101111;
         4'ha: hex_to_seg = 7'b1110111;
         4'hb: hex_to_seg = 7'b1111100;  // lower case b
         4'hc: hex_to_seg = 7'b0111001;
         4'hd: hex_to_seg = 7'b1011110;  // lower case d
         4'he: hex_to_seg = 7'b1111001;
         default: hex_to_seg = 7'b1110001;
      endcase
   endfunction

   ////////////////////////////////////////
   // consumer side of req/ack

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         disp_ack   <= 1'b0;
         shown_word <= '0;
      end else if (disp_req && !disp_ack) begin
         shown_word <= disp_word;   // phase 2, latch then ack
         disp_ack   <= 1'b1;
      end else if (!disp_req && disp_ack) begin
         disp_ack   <= 1'b0;        // phase 4
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_DIGITS; i++) begin
         seg_next[i] = hex_to_seg(shown_word[WORD_BITS-1-i*$bits(hex_digit_t) -: 4]);
      end
   end

   // one cycle behind the latch
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         seg <= {NUM_DIGITS{hex_to_seg(4'h0)}};
      end else begin
         seg <= seg_next;
      end
   end

   // producer keeps req up until it has seen ack
   a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(disp_ack) |-> $past(disp_req) && disp_req);

endmodule

/* rtl/console_top.sv */
/* front-panel console top level
   buttons and switches in, processor reset, clock enable, release
   and eight hex digits of the chosen debug word out */
`timescale 1ns/1ps

module console_top (
   input  logic                             clk,
   input  logic                             rst_n,
   input  panel_types_pkg::panel_switches_t sw,
   input  panel_types_pkg::debug_word_t     io_word,
   input  panel_types_pkg::debug_word_t     pc_word,
   input  panel_types_pkg::debug_word_t     instr_word,
   output logic                             proc_rst_n,
   output logic                             proc_clk_en,
   output logic                             proc_release,
   output logic                             io_sel,
   output panel_types_pkg::seg_bank_t       seg
);
   import panel_types_pkg::*;

   panel_state_t state;       // filtered panel inputs
   logic         disp_req;
   logic         disp_ack;
   debug_word_t  disp_word;

   ////////////////////////////////////////
   // panel and processor control

   panel_inputs panel_inputs_i (
      .clk   (clk),
      .rst_n (rst_n),
      .sw    (sw),
      .state (state)
   );

   run_control run_control_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .state        (state),
      .proc_rst_n   (proc_rst_n),
      .proc_clk_en  (proc_clk_en),
      .proc_release (proc_release),
      .io_sel       (io_sel)
   );

   ////////////////////////////////////////
   // debug display

   display_capture display_capture_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .state      (state),
      .io_word    (io_word),
      .pc_word    (pc_word),
      .instr_word (instr_word),
      .disp_ack   (disp_ack),
      .disp_req   (disp_req),
      .disp_word  (disp_word)
   );

   seg_display seg_display_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .disp_req  (disp_req),
      .disp_word (disp_word),
      .disp_ack  (disp_ack),
      .seg       (seg)
   );

endmodule

/* testbench/console_model.svh */
/* reference model for the console testbench, included inside the tb module
   segment font, display word selection and button filter rules */
`ifndef CONSOLE_MODEL_SVH
`define CONSOLE_MODEL_SVH

// digits that light each segment, bit n set = hex digit n lit
function automatic logic [15:0] lit_digits(input int s);
   case (s)
      0: return 16'hD7ED;      // a
      1: return 16'h279F;      // b
      2: return 16'h2FFB;      // c
      3: return 16'h7B6D;      // d
      4: return 16'hFD45;      // e
      5: return 16'hDF71;      // f
      default: return 16'hEF7C; // g
   endcase
endfunction

// pattern g..a for one nibble
function automatic seg_pattern_t hex_font(input hex_digit_t nib);
   seg_pattern_t pat;
   logic [15:0]  mask;
   for (int s = 0; s < SEG_BITS; s++) begin
      mask   = lit_digits(s);
      pat[s] = mask[nib];
   end
   return pat;
endfunction

// digit 0 carries the top nibble
function automatic seg_bank_t seg_of_word(input debug_word_t w);
   seg_bank_t bank;
   for (int d = 0; d < NUM_DIGITS; d++) begin
      bank[d] = hex_font(w[WORD_BITS-1-4*d -: 4]);
   end
   return bank;
endfunction

function automatic debug_word_t pick_word(input logic show_io, input logic show_addr,
                                          input debug_word_t io_w, input debug_word_t pc_w,
                                          input debug_word_t instr_w);
   if (show_io) return io_w;
   return show_addr ? pc_w : instr_w;    // address or instruction
endfunction

// sync plus run length, from button edge to filtered edge
function automatic int filter_delay();
   return SYNC_STAGES + DEBOUNCE_CYCLES;
endfunction

// a pulse reaches the output only if held long enough
function automatic bit pulse_passes(input int width);
   return width >= DEBOUNCE_CYCLES;
endfunction

`endif

/* testbench/console_tb.sv */
/* testbench for the front-panel console
   random buttons, switches and words into console_top, outputs
   compared with the reference model in console_model.svh */
`timescale 1ns/1ps

module console_tb;
   import console_pkg::*;
   import panel_types_pkg::*;

   `include "console_model.svh"

   logic            clk = 1'b0;
   logic            rst_n;
   panel_switches_t sw;
   debug_word_t     io_word;
   debug_word_t     pc_word;
   debug_word_t     instr_word;
   logic            proc_rst_n;
   logic            proc_clk_en;
   logic            proc_release;
   logic            io_sel;
   seg_bank_t       seg;

   logic [31:0] rng_state = 32'haa03;
   int          errors = 0;
   int          checks = 0;
   bit          count_on = 1'b0;  // pulse counting window
   int          en_pulses = 0;
   int          rel_pulses = 0;
   int          cycles;

   console_top dut_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .sw           (sw),
      .io_word      (io_word),
      .pc_word      (pc_word),
      .instr_word   (instr_word),
      .proc_rst_n   (proc_rst_n),
      .proc_clk_en  (proc_clk_en),
      .proc_release (proc_release),
      .io_sel       (io_sel),
      .seg          (seg)
   );

   always #2 clk = ~clk;   // 4 ns period

   // high cycles of the step tick and the release
   always @(negedge clk) begin
      if (count_on) begin
         if (proc_clk_en) en_pulses++;
         if (proc_release) rel_pulses++;
      end
   end

   ////////////////////////////////////////
   // helpers

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

   function automatic int rand_range(input int lo, input int hi);
      return lo + int'(next_rand() % 32'(hi - lo + 1));
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_int(input string name, input int got, input int exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_seg(input seg_bank_t exp);
      checks++;
      assert (seg === exp) else begin
         errors++;
         $display("[ERROR] %0t seg: got %h expected %h", $time, seg, exp);
      end
   endtask

   task automatic wait_rst_n(input logic v, input int limit, output int n);
      n = 0;
      @(negedge clk);   // first sample, still in the calling cycle
      while (proc_rst_n !== v && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (proc_rst_n !== v) begin
         errors++;
         $display("proc_rst_n did not reach %b within %0d cycles", v, limit);
      end
   endtask

   task automatic wait_release(input logic v, input int limit);
      int n;
      n = 0;
      while (proc_release !== v && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (proc_release !== v) begin
         errors++;
         $display("proc_release did not reach %b within %0d cycles", v, limit);
      end
   endtask

   task automatic set_button(input bit step, input logic v);
      if (step) sw.step_btn <= v;
      else sw.release_btn <= v;
   endtask

   // real presses mixed with short glitches, returns expected pulses
   task automatic press_sequence(input bit step, input int events, output int presses);
      int width;
      int gap;
      presses = 0;
      for (int e = 0; e < events; e++) begin
         if (next_rand() % 2 == 1) width = rand_range(filter_delay() + 2, filter_delay() + 16);
         else width = rand_range(1, DEBOUNCE_CYCLES - 4);   // glitch
         gap = rand_range(filter_delay() + 4, filter_delay() + 16);
         @(posedge clk);
         set_button(step, 1'b1);
         repeat (width) @(posedge clk);
         set_button(step, 1'b0);
         repeat (gap) @(posedge clk);   // let the filter fall back
         if (pulse_passes(width)) presses++;
      end
   endtask

   ////////////////////////////////////////
   // test sequence

   initial begin
      int          presses;
      seg_bank_t   want;
      debug_word_t w_io;
      debug_word_t w_pc;
      debug_word_t w_instr;
      logic        s_io;
      logic        s_addr;
      logic        s_sel;
      rst_n      <= 1'b0;
      sw         <= '0;
      io_word    <= '0;
      pc_word    <= '0;
      instr_word <= '0;

      // outputs quiet while rst_n is low
      repeat (9) @(posedge clk);
      @(negedge clk);
      check_bit("proc_rst_n", proc_rst_n, 1'b0);
      check_bit("proc_clk_en", proc_clk_en, 1'b0);
      check_bit("proc_release", proc_release, 1'b0);
      check_seg(seg_of_word('0));
      @(posedge clk);
      rst_n <= 1'b1;
      wait_rst_n(1'b1, RESET_HOLD_CYCLES + 4, cycles);
      check_int("rst_n to proc_rst_n cycles", cycles, RESET_HOLD_CYCLES);

      // reset button holds the processor, then the hold time runs
      @(posedge clk);
      sw.reset_btn <= 1'b1;
      wait_rst_n(1'b0, filter_delay() + 4, cycles);
      for (int i = 0; i < 40; i++) begin
         @(negedge clk);
         check_bit("proc_rst_n", proc_rst_n, 1'b0);
         check_bit("proc_clk_en", proc_clk_en, 1'b0);
      end
      @(posedge clk);
      sw.reset_btn <= 1'b0;
      wait_rst_n(1'b1, filter_delay() + RESET_HOLD_CYCLES + 10, cycles);
      check_int("button to proc_rst_n cycles", cycles, filter_delay() + RESET_HOLD_CYCLES);

      // free run, enable every cycle, release follows the button
      @(posedge clk);
      sw.run_mode <= 1'b1;
      repeat (SYNC_STAGES + 2) @(negedge clk);
      for (int i = 0; i < 50; i++) begin
         @(negedge clk);
         check_bit("proc_clk_en", proc_clk_en, 1'b1);
      end
      @(posedge clk);
      sw.release_btn <= 1'b1;
      wait_release(1'b1, filter_delay() + 4);
      for (int i = 0; i < 30; i++) begin
         @(negedge clk);
         check_bit("proc_release", proc_release, 1'b1);
      end
      @(posedge clk);
      sw.release_btn <= 1'b0;
      wait_release(1'b0, filter_delay() + 4);

      // single step, one tick per real press
      @(posedge clk);
      sw.run_mode <= 1'b0;
      repeat (SYNC_STAGES + 4) @(posedge clk);
      en_pulses  = 0;
      rel_pulses = 0;
      count_on   = 1'b1;
      press_sequence(1'b1, 12, presses);
      repeat (filter_delay() + 4) @(posedge clk);
      count_on = 1'b0;
      check_int("proc_clk_en pulses", en_pulses, presses);
      check_int("proc_release pulses", rel_pulses, 0);

      en_pulses  = 0;
      rel_pulses = 0;
      count_on   = 1'b1;
      press_sequence(1'b0, 12, presses);
      repeat (filter_delay() + 4) @(posedge clk);
      count_on = 1'b0;
      check_int("proc_release pulses", rel_pulses, presses);
      check_int("proc_clk_en pulses", en_pulses, 0);

      // display words and io_sel
      for (int t = 0; t < 20; t++) begin
         w_io    = next_rand();
         w_pc    = next_rand();
         w_instr = next_rand();
         s_io    = next_rand() % 2 == 1;
         s_addr  = next_rand() % 2 == 1;
         s_sel   = next_rand() % 2 == 1;
         want    = seg_of_word(pick_word(s_io, s_addr, w_io, w_pc, w_instr));
         @(posedge clk);
         io_word      <= w_io;
         pc_word      <= w_pc;
         instr_word   <= w_instr;
         sw.show_io   <= s_io;
         sw.show_addr <= s_addr;
         sw.io_sel    <= s_sel;
         cycles = 0;
         while ((seg !== want || io_sel !== s_sel) && cycles < 10 + SYNC_STAGES + 2) begin
            @(negedge clk);
            cycles++;
         end
         check_seg(want);
         check_bit("io_sel", io_sel, s_sel);
      end

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+testbench
rtl/console_pkg.sv
rtl/panel_types_pkg.sv
rtl/button_debouncer.sv
rtl/panel_inputs.sv
rtl/run_control.sv
rtl/display_capture.sv
rtl/seg_display.sv
rtl/console_top.sv
testbench/console_tb.sv

/* Makefile */
# Verilator build and run for the front-panel console testbench

VERILATOR ?= verilator
TOP       ?= console_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= PASS: all tests

SOURCES := $(wildcard rtl/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
